/* verilog.f */
+incdir+hdl
hdl/tmu_pkg.sv
hdl/tmu_point_if.sv
hdl/tmu_addr_if.sv
hdl/tmu_scan.sv
hdl/tmu_addresses.sv
hdl/tmu_fetch.sv
hdl/tmu.sv
tests/tmu_clkgen.sv
tests/tb_tmu.sv

/* Makefile */
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tmu -f verilog.f
	./obj_dir/Vtb_tmu | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* tests/tb_tmu.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_tmu;

	localparam int RUNS = 4;
	localparam int TIMEOUT_CYCLES = RUNS * 30 * 20 + 500; // 30 pixels max per run.
	localparam logic [31:0] SEED = 32'hbd1baf6b;

	logic sys_clk;
	logic sys_rst;
	logic start_i;
	logic busy_o;
	tmu_pkg::word_addr_t src_fbuf_i, dst_fbuf_i;
	tmu_pkg::coord_t src_hres_i, dst_hres_i, dst_x0_i, dst_y0_i;
	tmu_pkg::coord_t width_i, height_i, u0_i, v0_i, du_i, dv_i;
	logic tex_rd_stb_o;
	tmu_pkg::word_addr_t tex_addr_o;
	logic tex_rd_ack_i = 1'b0; // memory side, driven by the model below.
	logic tex_data_valid_i = 1'b0;
	tmu_pkg::texel_t tex_data_i = '0;
	logic pix_stb_o;
	tmu_pkg::word_addr_t pix_addr_o;
	tmu_pkg::texel_t pix_data_o;
	logic pix_ack_i = 1'b0;

	int errors;
	int writes = 0; // acked pixel writes, all runs.
	int pixels; // expected writes, all runs.
	logic [31:0] cfg_rng;
	logic [31:0] bus_rng = ~SEED; // separate stream for the bus.
	tmu_pkg::word_addr_t exp_tex_q[$]; // reference model output, raster order.
	tmu_pkg::word_addr_t exp_pix_addr_q[$];
	tmu_pkg::texel_t exp_pix_data_q[$];
	logic rd_pending; // read taken, data not returned yet.
	int rd_wait;
	tmu_pkg::word_addr_t rd_addr;
	logic rd_stall; // strobe high and unacked at the last edge.
	logic pix_stall;
	logic busy_q;
	tmu_pkg::word_addr_t last_tex_addr, last_pix_addr;
	tmu_pkg::texel_t last_pix_data;

	tmu_clkgen clkgen_i (.sys_clk_o(sys_clk), .sys_rst_o(sys_rst));

	tmu tmu_i (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// next config value in 0..n-1.
	function automatic int cfg_pick(input int n);
		cfg_rng = lcg_next(cfg_rng);
		return int'(cfg_rng[30:16]) % n;
	endfunction

	// texel memory contents, scrambled from the whole address.
	function automatic tmu_pkg::texel_t texel_at(input tmu_pkg::word_addr_t a);
		return (a * 16'h9e37) ^ 16'h5a5a;
	endfunction

	task automatic value_error(input string name, input int got, input int exp);
		errors++;
		$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	task automatic finish_sim();
		$display("%0d errors, %0d of %0d pixels written, %0d reads left", errors, writes,
			pixels, exp_tex_q.size());
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	endtask

	// random rectangle and mapping, plus the reads and writes it must produce.
	task automatic setup_run(input int run);
		int w, h, du, dv, x0, y0, u0, v0;
		int sh, dh, sf, df, s, d;
		w = 1 + cfg_pick(6);
		h = 1 + cfg_pick(5);
		du = (run == 1) ? 2 : (run == 2) ? 0 : cfg_pick(4); // downscale, replicate.
		dv = (run == 1) ? 2 : (run == 2) ? 0 : cfg_pick(4);
		x0 = cfg_pick(64);
		y0 = cfg_pick(64);
		u0 = cfg_pick(64);
		v0 = cfg_pick(64);
		sh = 16 + cfg_pick(200);
		dh = 16 + cfg_pick(200);
		sf = cfg_pick(32768);
		df = 32768 + cfg_pick(32768);
		@(posedge sys_clk);
		width_i <= tmu_pkg::coord_t'(w);
		height_i <= tmu_pkg::coord_t'(h);
		du_i <= tmu_pkg::coord_t'(du);
		dv_i <= tmu_pkg::coord_t'(dv);
		dst_x0_i <= tmu_pkg::coord_t'(x0);
		dst_y0_i <= tmu_pkg::coord_t'(y0);
		u0_i <= tmu_pkg::coord_t'(u0);
		v0_i <= tmu_pkg::coord_t'(v0);
		src_hres_i <= tmu_pkg::coord_t'(sh);
		dst_hres_i <= tmu_pkg::coord_t'(dh);
		src_fbuf_i <= tmu_pkg::word_addr_t'(sf);
		dst_fbuf_i <= tmu_pkg::word_addr_t'(df);
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < w; c++) begin
				// coordinates wrap at 11 bits, addresses at 16.
				s = sf + sh * ((v0 + r * dv) % 2048) + (u0 + c * du) % 2048;
				d = df + dh * ((y0 + r) % 2048) + (x0 + c) % 2048;
				exp_tex_q.push_back(tmu_pkg::word_addr_t'(s));
				exp_pix_addr_q.push_back(tmu_pkg::word_addr_t'(d));
				exp_pix_data_q.push_back(texel_at(tmu_pkg::word_addr_t'(s)));
			end
		end
		pixels += w * h;
		$display("run %0d: %0d x %0d, du %0d, dv %0d", run, w, h, du, dv);
	endtask

	task automatic copy_run(input int run);
		setup_run(run);
		start_i <= 1'b1; // same edge as the config.
		@(posedge sys_clk);
		start_i <= 1'b0;
		while (!busy_o) @(posedge sys_clk);
		if (run == 2) begin
			@(posedge sys_clk);
			start_i <= 1'b1; // must be ignored, copy in flight.
			@(posedge sys_clk);
			start_i <= 1'b0;
		end
		while (busy_o) @(posedge sys_clk);
		assert (writes == pixels) else value_error("pixel write count", writes, pixels);
		assert (exp_tex_q.size() == 0) else note_failure("texel reads missing after busy_o fell");
	endtask

	initial begin
		errors = 0;
		pixels = 0;
		cfg_rng = SEED;
		start_i = 1'b0;
		src_fbuf_i = '0;
		dst_fbuf_i = '0;
		src_hres_i = '0;
		dst_hres_i = '0;
		dst_x0_i = '0;
		dst_y0_i = '0;
		width_i = '0;
		height_i = '0;
		u0_i = '0;
		v0_i = '0;
		du_i = '0;
		dv_i = '0;
		@(posedge sys_clk); // reset is surely high by the first edge.
		while (sys_rst) @(posedge sys_clk);
		repeat (3) begin
			@(posedge sys_clk);
			assert (!busy_o && !tex_rd_stb_o && !pix_stb_o)
				else note_failure("busy_o or a strobe is high after reset with no start");
		end
		for (int run = 0; run < RUNS; run++)
			copy_run(run);
		finish_sim();
	end

	// memory model with random back-pressure, and the bus checks.
	always @(posedge sys_clk) begin
		bus_rng = lcg_next(bus_rng);
		tex_rd_ack_i <= bus_rng[16];
		pix_ack_i <= bus_rng[17];
		tex_data_valid_i <= 1'b0; // one cycle pulse.
		if (sys_rst) begin
			rd_pending = 1'b0;
			rd_stall = 1'b0;
			pix_stall = 1'b0;
			busy_q = 1'b0;
		end else begin
			if (rd_stall)
				assert (tex_rd_stb_o && tex_addr_o == last_tex_addr)
					else note_failure("texel read request changed before its ack");
			if (pix_stall)
				assert (pix_stb_o && pix_addr_o == last_pix_addr && pix_data_o == last_pix_data)
					else note_failure("pixel write changed before its ack");
			if (tex_rd_stb_o && tex_rd_ack_i) begin
				assert (exp_tex_q.size() != 0) else note_failure("texel read with none expected");
				if (exp_tex_q.size() != 0) begin
					assert (tex_addr_o == exp_tex_q[0])
						else value_error("tex_addr_o", tex_addr_o, exp_tex_q[0]);
					exp_tex_q.delete(0);
				end
				rd_pending = 1'b1;
				rd_wait = 1 + int'(bus_rng[19:18]); // 1 to 4 cycles.
				rd_addr = tex_addr_o;
			end else if (rd_pending) begin
				rd_wait--;
				if (rd_wait == 0) begin
					tex_data_valid_i <= 1'b1;
					tex_data_i <= texel_at(rd_addr);
					rd_pending = 1'b0;
				end
			end
			if (pix_stb_o && pix_ack_i) begin
				writes++;
				assert (exp_pix_addr_q.size() != 0) else note_failure("pixel write with none expected");
				if (exp_pix_addr_q.size() != 0) begin
					assert (pix_addr_o == exp_pix_addr_q[0])
						else value_error("pix_addr_o", pix_addr_o, exp_pix_addr_q[0]);
					assert (pix_data_o == exp_pix_data_q[0])
						else value_error("pix_data_o", pix_data_o, exp_pix_data_q[0]);
					exp_pix_addr_q.delete(0);
					exp_pix_data_q.delete(0);
				end
			end
			if (busy_q && !busy_o)
				assert (exp_pix_addr_q.size() == 0)
					else note_failure("busy_o fell before the last pixel write was acked");
			rd_stall = tex_rd_stb_o && !tex_rd_ack_i;
			pix_stall = pix_stb_o && !pix_ack_i;
			busy_q = busy_o;
			last_tex_addr = tex_addr_o;
			last_pix_addr = pix_addr_o;
			last_pix_data = pix_data_o;
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycles++;
		end
		note_failure("timeout, the copies did not finish in time");
		finish_sim();
	end

endmodule

`default_nettype wire

/* tests/tmu_clkgen.sv */
`timescale 1ns/100ps
`default_nettype none

// 4 ns clock, reset high for the first 10 rising edges.
module tmu_clkgen (
	output logic sys_clk_o,
	output logic sys_rst_o
);

	initial begin
		sys_clk_o = 1'b0;
		forever #2 sys_clk_o = ~sys_clk_o; // half period.
	end

	initial begin
		sys_rst_o = 1'b1;
		repeat (10) @(posedge sys_clk_o);
		sys_rst_o <= 1'b0; // released on an edge like other inputs.
	end

endmodule

`default_nettype wire

/* hdl/tmu.sv */
`timescale 1ns/100ps
`default_nettype none

module tmu (
	input  logic                sys_clk,
	input  logic                sys_rst,
	input  logic                start_i,
	output logic                busy_o,
	input  tmu_pkg::word_addr_t src_fbuf_i,
	input  tmu_pkg::coord_t     src_hres_i,
	input  tmu_pkg::word_addr_t dst_fbuf_i,
	input  tmu_pkg::coord_t     dst_hres_i,
	input  tmu_pkg::coord_t     dst_x0_i,
	input  tmu_pkg::coord_t     dst_y0_i,
	input  tmu_pkg::coord_t     width_i,
	input  tmu_pkg::coord_t     height_i,
	input  tmu_pkg::coord_t     u0_i,
	input  tmu_pkg::coord_t     v0_i,
	input  tmu_pkg::coord_t     du_i,
	input  tmu_pkg::coord_t     dv_i,
	output logic                tex_rd_stb_o,
	output tmu_pkg::word_addr_t tex_addr_o,
	input  logic                tex_rd_ack_i,
	input  logic                tex_data_valid_i,
	input  tmu_pkg::texel_t     tex_data_i,
	output logic                pix_stb_o,
	output tmu_pkg::word_addr_t pix_addr_o,
	output tmu_pkg::texel_t     pix_data_o,
	input  logic                pix_ack_i
);

	logic scan_busy;
	logic addr_busy;
	logic fetch_busy;
	logic scan_start; // start, blocked while anything is in flight.

	tmu_point_if point_if ();
	tmu_addr_if  addr_if ();

	assign scan_start = start_i & ~busy_o;

	tmu_scan scan_i (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.start_i  (scan_start),
		.dst_x0_i (dst_x0_i),
		.dst_y0_i (dst_y0_i),
		.width_i  (width_i),
		.height_i (height_i),
		.u0_i     (u0_i),
		.v0_i     (v0_i),
		.du_i     (du_i),
		.dv_i     (dv_i),
		.busy_o   (scan_busy),
		.point_o  (point_if.scan_mp)
	);

	tmu_addresses addresses_i (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.src_fbuf_i (src_fbuf_i),
		.dst_fbuf_i (dst_fbuf_i),
		.src_hres_i (src_hres_i),
		.dst_hres_i (dst_hres_i),
		.busy_o     (addr_busy),
		.point_i    (point_if.addr_mp),
		.addr_o     (addr_if.addr_mp)
	);

	tmu_fetch fetch_i (
		.sys_clk          (sys_clk),
		.sys_rst          (sys_rst),
		.addr_i           (addr_if.fetch_mp),
		.busy_o           (fetch_busy),
		.tex_rd_stb_o     (tex_rd_stb_o),
		.tex_addr_o       (tex_addr_o),
		.tex_rd_ack_i     (tex_rd_ack_i),
		.tex_data_valid_i (tex_data_valid_i),
		.tex_data_i       (tex_data_i),
		.pix_stb_o        (pix_stb_o),
		.pix_addr_o       (pix_addr_o),
		.pix_data_o       (pix_data_o),
		.pix_ack_i        (pix_ack_i)
	);

	// the busy flags overlap at each handoff, so this has no gap.
	assign busy_o = scan_busy | addr_busy | fetch_busy;

endmodule

`default_nettype wire

/* hdl/tmu_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module tmu_fetch (
	input  logic                sys_clk,
	input  logic                sys_rst,
	tmu_addr_if.fetch_mp        addr_i,
	output logic                busy_o,
	output logic                tex_rd_stb_o, // texel read request.
	output tmu_pkg::word_addr_t tex_addr_o,
	input  logic                tex_rd_ack_i,
	input  logic                tex_data_valid_i,
	input  tmu_pkg::texel_t     tex_data_i,
	output logic                pix_stb_o, // pixel write.
	output tmu_pkg::word_addr_t pix_addr_o,
	output tmu_pkg::texel_t     pix_data_o,
	input  logic                pix_ack_i
);

	tmu_pkg::fetch_state_t state;
	tmu_pkg::word_addr_t src_addr; // latched on accept.
	tmu_pkg::word_addr_t dst_addr;
	tmu_pkg::texel_t texel; // latched read data.

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= tmu_pkg::FETCH_IDLE;
		end else begin
			case (state)
				tmu_pkg::FETCH_IDLE: begin
					if (addr_i.stb)
						state <= tmu_pkg::FETCH_READ;
				end
				tmu_pkg::FETCH_READ: begin
					if (tex_rd_ack_i)
						state <= tmu_pkg::FETCH_WAIT; // request taken, data follows.
				end
				tmu_pkg::FETCH_WAIT: begin
					if (tex_data_valid_i)
						state <= tmu_pkg::FETCH_WRITE;
				end
				tmu_pkg::FETCH_WRITE: begin
					if (pix_ack_i)
						state <= tmu_pkg::FETCH_IDLE;
				end
				default: state <= tmu_pkg::FETCH_IDLE;
			endcase
		end
	end

	// payload registers.
	always_ff @(posedge sys_clk) begin
		if (state == tmu_pkg::FETCH_IDLE && addr_i.stb) begin
			src_addr <= addr_i.src_addr;
			dst_addr <= addr_i.dst_addr;
		end
		if (state == tmu_pkg::FETCH_WAIT && tex_data_valid_i)
			texel <= tex_data_i;
	end

	// only idle takes a new pair, which stalls everything upstream.
	assign addr_i.ack = (state == tmu_pkg::FETCH_IDLE);

	assign tex_rd_stb_o = (state == tmu_pkg::FETCH_READ);
	assign tex_addr_o = src_addr; // steady while the request waits.

	assign pix_stb_o = (state == tmu_pkg::FETCH_WRITE);
	assign pix_addr_o = dst_addr;
	assign pix_data_o = texel;

	assign busy_o = (state != tmu_pkg::FETCH_IDLE);

endmodule

`default_nettype wire

/* hdl/tmu_addresses.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tmu_defs.svh"

module tmu_addresses (
	input  logic                sys_clk,
	input  logic                sys_rst,
	input  tmu_pkg::word_addr_t src_fbuf_i, // texture base.
	input  tmu_pkg::word_addr_t dst_fbuf_i, // framebuffer base.
	input  tmu_pkg::coord_t     src_hres_i,
	input  tmu_pkg::coord_t     dst_hres_i,
	output logic                busy_o,
	tmu_point_if.addr_mp        point_i,
	tmu_addr_if.addr_mp         addr_o
);

	logic en; // whole pipe steps.
	logic s1_valid;
	logic s2_valid;
	logic [2*`TMU_COORD_W-1:0] src_row_off; // full width product.
	logic [2*`TMU_COORD_W-1:0] dst_row_off;
	tmu_pkg::word_addr_t s1_src_addr;
	tmu_pkg::word_addr_t s1_dst_addr;
	tmu_pkg::word_addr_t s2_src_addr;
	tmu_pkg::word_addr_t s2_dst_addr;

	assign en = addr_o.ack;
	assign point_i.ack = addr_o.ack; // ack passes straight through.

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else if (en) begin
			s1_valid <= point_i.stb;
			s2_valid <= s1_valid;
		end
	end

	assign src_row_off = src_hres_i * point_i.v;
	assign dst_row_off = dst_hres_i * point_i.y;

	// multiply-add, then a plain register stage.
	always_ff @(posedge sys_clk) begin
		if (en) begin
			s1_src_addr <= src_fbuf_i + tmu_pkg::word_addr_t'(src_row_off)
				+ tmu_pkg::word_addr_t'(point_i.u);
			s1_dst_addr <= dst_fbuf_i + tmu_pkg::word_addr_t'(dst_row_off)
				+ tmu_pkg::word_addr_t'(point_i.x);
			s2_src_addr <= s1_src_addr;
			s2_dst_addr <= s1_dst_addr;
		end
	end

	assign addr_o.stb = s2_valid;
	assign addr_o.src_addr = s2_src_addr;
	assign addr_o.dst_addr = s2_dst_addr;

	assign busy_o = s1_valid | s2_valid;

endmodule

`default_nettype wire

/* hdl/tmu_scan.sv */
`timescale 1ns/100ps
`default_nettype none

module tmu_scan (
	input  logic            sys_clk,
	input  logic            sys_rst,
	input  logic            start_i,
	input  tmu_pkg::coord_t dst_x0_i, // rectangle origin.
	input  tmu_pkg::coord_t dst_y0_i,
	input  tmu_pkg::coord_t width_i,
	input  tmu_pkg::coord_t height_i,
	input  tmu_pkg::coord_t u0_i, // texture origin.
	input  tmu_pkg::coord_t v0_i,
	input  tmu_pkg::coord_t du_i, // per column.
	input  tmu_pkg::coord_t dv_i, // per row.
	output logic            busy_o,
	tmu_point_if.scan_mp    point_o
);

	tmu_pkg::coord_t col; // column inside the rectangle.
	tmu_pkg::coord_t row;
	tmu_pkg::coord_t u_acc; // running texture coordinates.
	tmu_pkg::coord_t v_acc;
	logic busy;
	logic xfer;
	logic last_col;
	logic last_row;

	assign xfer = point_o.stb & point_o.ack;
	assign last_col = (col == tmu_pkg::coord_t'(width_i - 1'b1));
	assign last_row = (row == tmu_pkg::coord_t'(height_i - 1'b1));

	// raster walk, counters move only when a point is taken.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			busy <= 1'b0;
			col <= '0;
			row <= '0;
		end else if (!busy) begin
			if (start_i) begin
				busy <= 1'b1;
				col <= '0;
				row <= '0;
			end
		end else if (xfer) begin
			if (last_col) begin
				col <= '0; // next row.
				if (last_row)
					busy <= 1'b0; // whole rectangle sent.
				else
					row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// u restarts every row, v steps once per row.
	always_ff @(posedge sys_clk) begin
		if (!busy && start_i) begin
			u_acc <= u0_i;
			v_acc <= v0_i;
		end else if (xfer) begin
			if (last_col) begin
				u_acc <= u0_i;
				v_acc <= v_acc + dv_i;
			end else begin
				u_acc <= u_acc + du_i;
			end
		end
	end

	assign point_o.stb = busy; // first point the cycle after start.
	assign point_o.x = dst_x0_i + col;
	assign point_o.y = dst_y0_i + row;
	assign point_o.u = u_acc;
	assign point_o.v = v_acc;

	assign busy_o = busy;

endmodule

`default_nettype wire

/* hdl/tmu_addr_if.sv */
`timescale 1ns/100ps
`default_nettype none

// source and destination word addresses for one pixel.
interface tmu_addr_if;

	logic stb;
	logic ack; // high only when fetch can take a pair.
	tmu_pkg::word_addr_t src_addr;
	tmu_pkg::word_addr_t dst_addr;

	modport addr_mp (
		output stb,
		output src_addr,
		output dst_addr,
		input  ack
	);

	modport fetch_mp (
		input  stb,
		input  src_addr,
		input  dst_addr,
		output ack
	);

endinterface

`default_nettype wire

/* hdl/tmu_point_if.sv */
`timescale 1ns/100ps
`default_nettype none

// one scan point with its strobe/ack pair.
interface tmu_point_if;

	logic stb; // point offered.
	logic ack; // pipeline advances.
	tmu_pkg::coord_t x; // destination pixel.
	tmu_pkg::coord_t y;
	tmu_pkg::coord_t u; // source texel.
	tmu_pkg::coord_t v;

	modport scan_mp (
		output stb,
		output x,
		output y,
		output u,
		output v,
		input  ack
	);

	modport addr_mp (
		input  stb,
		input  x,
		input  y,
		input  u,
		input  v,
		output ack
	);

endinterface

`default_nettype wire

/* hdl/tmu_pkg.sv */
`default_nettype none

`include "tmu_defs.svh"

package tmu_pkg;

	typedef logic [`TMU_ADDR_W-1:0] word_addr_t; // in 16-bit words.
	typedef logic [`TMU_COORD_W-1:0] coord_t;
	typedef logic [`TMU_TEXEL_W-1:0] texel_t; // rgb565.

	// fetch sequencer, one access at a time.
	typedef enum logic [1:0] {
		FETCH_IDLE  = 2'd0,
		FETCH_READ  = 2'd1,
		FETCH_WAIT  = 2'd2,
		FETCH_WRITE = 2'd3
	} fetch_state_t;

endpackage

`default_nettype wire

/* hdl/tmu_defs.svh */
`ifndef TMU_DEFS_SVH
`define TMU_DEFS_SVH

// framebuffer word address, counted in 16-bit words.
`define TMU_ADDR_W 16

// pixel and texel coordinates, increments, horizontal resolutions.
`define TMU_COORD_W 11

// one rgb565 texel.
`define TMU_TEXEL_W 16

`endif
